// ==== Bender.yml ====
package:
  name: sram_subsys

sources:
  - source/store_cfg_pkg.sv
  - source/tentry_pkg.sv
  - source/word_sram.sv
  - source/tentry_packer.sv
  - source/load_port.sv
  - source/sram_controller.sv
  - source/sram_subsys.sv
  - target: simulation
    files:
      - bench/tb_sram_subsys.sv

// ==== bench/tb_sram_subsys.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_sram_subsys
	import store_cfg_pkg::*;
	import tentry_pkg::*;
;

	localparam int ADDR_BITS = 5;
	localparam int STORE_WORDS = 1 << ADDR_BITS;
	localparam int CLK_PERIOD = 100;
	// descriptors, PE operations and init words over all tests, rounded up
	localparam int OP_BUDGET = 80 + 250 + STORE_WORDS;
	localparam int WATCHDOG_NS = OP_BUDGET * 20 * CLK_PERIOD;

	logic                  clk;
	logic                  rst_n;
	logic                  i_load_start;
	logic                  i_load_req;
	logic [ENTRY_BITS-1:0] i_load_entry;
	logic                  o_load_ack;
	logic                  i_init;
	logic                  i_pe_request;
	logic                  i_pe_send;
	logic [WORD_BITS-1:0]  i_send_data;
	logic [WORD_BITS-1:0]  o_rd_data;
	logic                  o_rd_valid;
	logic [SIZE_BITS-1:0]  o_t_size;
	logic                  o_busy;

	// reference store
	logic [WORD_BITS-1:0]   model_mem [STORE_WORDS];
	logic [HEADER_BITS-1:0] m_header = FREE_HEADER;
	int                     m_data = 0;
	int                     m_rd = 0;
	int                     m_wr = 0;
	int                     m_count = 0;

	int  errors = 0;
	int  tests_run = 0;
	int  tests_failed = 0;
	int  sent_count = 0;
	int  ack_rises = 0;
	logic ack_q = 1'b0;
	logic req_q = 1'b0;

	sram_subsys #(
		.ADDR_BITS (ADDR_BITS)
	) uut (
		.clk          (clk),
		.rst_n        (rst_n),
		.i_load_start (i_load_start),
		.i_load_req   (i_load_req),
		.i_load_entry (i_load_entry),
		.o_load_ack   (o_load_ack),
		.i_init       (i_init),
		.i_pe_request (i_pe_request),
		.i_pe_send    (i_pe_send),
		.i_send_data  (i_send_data),
		.o_rd_data    (o_rd_data),
		.o_rd_valid   (o_rd_valid),
		.o_t_size     (o_t_size),
		.o_busy       (o_busy)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("watchdog expired, the run did not finish in time");
		$display("Result: FAILED");
		$finish;
	end

	task automatic check_value(input logic [WORD_BITS-1:0] got,
		input logic [WORD_BITS-1:0] exp, input string what);
		if (got !== exp) begin
			$display("mismatch at %0t ns: %s, got %0h expected %0h", $time, what, got, exp);
			errors++;
		end
	endtask

	// handshake watch, sampled mid-cycle
	always @(negedge clk) begin
		if (o_load_ack && !ack_q) begin
			ack_rises++;
		end
		// req_q is the level the port saw on the edge that dropped ack
		if (ack_q && !o_load_ack) begin
			check_value(req_q, 1'b0, "req before ack falls");
		end
		ack_q <= o_load_ack;
		req_q <= i_load_req;
	end

	task automatic next_cycle();
		@(posedge clk);
		#10;
	endtask

	task automatic wait_ack(input logic level);
		int n;
		n = 0;
		while (o_load_ack !== level && n < 20) begin
			next_cycle();
			n++;
		end
		if (o_load_ack !== level) begin
			$display("host handshake stalled, ack never went to %0b", level);
			errors++;
		end
	endtask

	task automatic wait_busy(input logic level, input int limit);
		int n;
		n = 0;
		while (o_busy !== level && n < limit) begin
			next_cycle();
			n++;
		end
		if (o_busy !== level) begin
			$display("controller stuck, busy never went to %0b", level);
			errors++;
		end
	endtask

	// descriptor into a word following the storage layout
	function automatic logic [WORD_BITS-1:0] pack_entry(input logic [ENTRY_BITS-1:0] e);
		logic [WORD_BITS-1:0] w;
		logic [SLOT_BITS-1:0] slot;
		int k;
		w = '0;
		w[WORD_BITS-1 -: HEADER_BITS] = e[ENTRY_BITS-1 -: HEADER_BITS];
		for (k = 0; k < SLOT_COUNT; k++) begin
			slot = {e[k*VALUE_BITS +: VALUE_BITS], {ACC_BITS{1'b0}}};
			w[k*SLOT_BITS +: SLOT_BITS] = slot;
		end
		return w;
	endfunction

	function automatic logic [WORD_BITS-1:0] random_word();
		logic [WORD_BITS-1:0] w;
		int i;
		for (i = 0; i < WORD_BITS / 32; i++) begin
			w[i*32 +: 32] = $urandom;
		end
		return w;
	endfunction

	task automatic model_load(input logic [ENTRY_BITS-1:0] e, output bit ended);
		logic [WORD_BITS-1:0] w;
		ended = 1'b0;
		w = pack_entry(e);
		if (e[ENTRY_VALID_POS]) begin
			if (e[ENTRY_LAST_HI:ENTRY_LAST_LO] != 3'd0) begin
				model_mem[m_data] = w;
				m_header = e[ENTRY_BITS-1 -: HEADER_BITS];
				m_count += e[ENTRY_LAST_HI:ENTRY_LAST_LO];
				ended = 1'b1;
			end else if (m_data == STORE_WORDS - 1) begin
				w[WORD_BITS-1 -: HEADER_BITS] = FULL_HEADER;
				model_mem[m_data] = w;
				m_header = FULL_HEADER;
				m_count += TUPLES_PER_WORD;
				ended = 1'b1;
			end else begin
				model_mem[m_data] = w;
				m_count += TUPLES_PER_WORD;
				m_data++;
			end
		end
	endtask

	task automatic send_entry(input logic [ENTRY_BITS-1:0] e);
		i_load_entry = e;
		i_load_req = 1'b1;
		sent_count++;
		next_cycle();
		wait_ack(1'b1);
		i_load_req = 1'b0;
		next_cycle();
		wait_ack(1'b0);
	endtask

	task automatic load_store(input int body_len, input int invalid_pct);
		logic [ENTRY_BITS-1:0] e;
		bit valid;
		bit ended;
		int i;
		i_load_start = 1'b1;
		next_cycle();
		i_load_start = 1'b0;
		wait_busy(1'b1, 4);
		m_data = 0;
		m_rd = 0;
		m_wr = 0;
		m_count = 0;
		ended = 1'b0;
		i = 0;
		while (!ended && i < body_len) begin
			valid = ($urandom % 100) >= invalid_pct;
			// dropped descriptors may still carry a last count
			e = {valid, valid ? 3'd0 : 3'($urandom), ENTRY_VALUES_BITS'($urandom)};
			send_entry(e);
			model_load(e, ended);
			check_value(o_t_size, m_count, "tuple count after descriptor");
			i++;
		end
		if (!ended) begin
			e = {1'b1, 3'(1 + $urandom % 7), ENTRY_VALUES_BITS'($urandom)};
			send_entry(e);
			model_load(e, ended);
			check_value(o_t_size, m_count, "tuple count after last descriptor");
		end
		check_value(o_busy, 1'b0, "busy after load");
	endtask

	// fixed latency, valid two edges after the accepting edge
	task automatic pe_read();
		i_pe_request = 1'b1;
		next_cycle();
		i_pe_request = 1'b0;
		next_cycle();
		check_value(o_rd_valid, 1'b0, "read valid one edge after request");
		next_cycle();
		check_value(o_rd_valid, 1'b1, "read valid two edges after request");
		check_value(o_rd_data, model_mem[m_rd], $sformatf("read data at word %0d", m_rd));
		m_rd = (m_rd == m_data) ? 0 : m_rd + 1;
		next_cycle();
		check_value(o_rd_valid, 1'b0, "read valid lasts one cycle");
	endtask

	task automatic pe_write(input logic [WORD_BITS-1:0] data);
		logic [HEADER_BITS-1:0] hdr;
		i_pe_send = 1'b1;
		i_send_data = data;
		next_cycle();
		i_pe_send = 1'b0;
		hdr = (m_wr == m_data) ? m_header : FREE_HEADER;
		model_mem[m_wr] = {hdr, data[WORD_BITS-HEADER_BITS-1:0]};
		m_wr = (m_wr == m_data) ? 0 : m_wr + 1;
		repeat (3) next_cycle();
	endtask

	task automatic init_pass();
		int a;
		int k;
		i_init = 1'b1;
		next_cycle();
		i_init = 1'b0;
		check_value(o_busy, 1'b1, "busy after init pulse");
		wait_busy(1'b0, 3 * STORE_WORDS + 8);
		for (a = 0; a <= m_data; a++) begin
			for (k = 0; k < SLOT_COUNT; k++) begin
				model_mem[a][k*SLOT_BITS +: ACC_BITS] = '0;
			end
		end
		m_rd = 0;
		m_wr = 0;
	endtask

	task automatic end_test(input string name, input int errors_before);
		tests_run++;
		if (errors == errors_before) begin
			$display("test %-16s ok", name);
		end else begin
			$display("test %-16s failed with %0d errors", name, errors - errors_before);
			tests_failed++;
		end
	endtask

	initial begin
		int e0;
		int i;
		int sent0;
		int acks0;
		logic [WORD_BITS-1:0] w;
		void'($urandom(10));
		rst_n = 1'b0;
		i_load_start = 1'b0;
		i_load_req = 1'b0;
		i_load_entry = '0;
		i_init = 1'b0;
		i_pe_request = 1'b0;
		i_pe_send = 1'b0;
		i_send_data = '0;
		repeat (3) @(posedge clk);
		#10;
		rst_n = 1'b1;
		check_value(o_busy, 1'b0, "busy after reset");
		check_value(o_rd_valid, 1'b0, "read valid after reset");
		check_value(o_load_ack, 1'b0, "ack after reset");
		check_value(o_t_size, '0, "tuple count after reset");

		e0 = errors;
		load_store(2 + $urandom % 8, 20);
		end_test("load_count", e0);

		// extra reads go past the last word and wrap
		e0 = errors;
		for (i = 0; i < m_data + 4; i++) begin
			pe_read();
		end
		end_test("read_order", e0);

		e0 = errors;
		for (i = 0; i <= m_data; i++) begin
			pe_write(random_word());
		end
		for (i = 0; i < 24; i++) begin
			if ($urandom % 2) begin
				pe_write(random_word());
			end else begin
				pe_read();
			end
		end
		end_test("write_back", e0);

		e0 = errors;
		for (i = 0; i <= m_data; i++) begin
			w = random_word();
			// one set bit per accumulation field
			for (int k = 0; k < SLOT_COUNT; k++) begin
				w[k*SLOT_BITS] = 1'b1;
			end
			pe_write(w);
		end
		init_pass();
		for (i = 0; i <= m_data; i++) begin
			pe_read();
		end
		end_test("init_pass", e0);

		e0 = errors;
		load_store(STORE_WORDS + 8, 0);
		// every address holds a non-last word
		check_value(o_t_size, STORE_WORDS * TUPLES_PER_WORD, "tuple count of a full store");
		for (i = 0; i < STORE_WORDS; i++) begin
			pe_read();
		end
		end_test("full_store", e0);

		e0 = errors;
		sent0 = sent_count;
		acks0 = ack_rises;
		load_store(12, 50);
		next_cycle();
		check_value(ack_rises - acks0, sent_count - sent0, "acks per request");
		for (i = 0; i <= m_data; i++) begin
			pe_read();
		end
		end_test("host_handshake", e0);

		$display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
		if (errors == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== source/load_port.sv ====
`timescale 1ns/100ps
`default_nettype none

module load_port
	import tentry_pkg::*;
(
	input  wire logic                  clk,
	input  wire logic                  rst_n,
	input  wire logic                  i_load_req,
	input  wire logic [ENTRY_BITS-1:0] i_load_entry,
	output logic                       o_load_ack,
	output logic                       o_entry_strobe,
	output logic      [ENTRY_BITS-1:0] o_entry
);

	typedef enum logic {
		WAIT_REQ,
		HANDSHAKE
	} port_state_t;

	port_state_t state;

	// handshake control
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= WAIT_REQ;
			o_load_ack <= 1'b0;
			o_entry_strobe <= 1'b0;
		end else begin
			o_entry_strobe <= 1'b0;
			case (state)
				WAIT_REQ: begin
					if (i_load_req) begin
						o_entry_strobe <= 1'b1;
						state <= HANDSHAKE;
					end
				end
				HANDSHAKE: begin
					// ack follows the strobe, then waits for req to drop
					if (!o_load_ack) begin
						o_load_ack <= 1'b1;
					end else if (!i_load_req) begin
						o_load_ack <= 1'b0;
						state <= WAIT_REQ;
					end
				end
				default: begin
					o_load_ack <= 1'b0;
					state <= WAIT_REQ;
				end
			endcase
		end
	end

	// descriptor captured with the req
	always_ff @(posedge clk) begin
		if (state == WAIT_REQ && i_load_req) begin
			o_entry <= i_load_entry;
		end
	end

endmodule

`default_nettype wire

// ==== source/sram_controller.sv ====
`timescale 1ns/100ps
`default_nettype none

module sram_controller
	import store_cfg_pkg::*;
	import tentry_pkg::*;
#(
	parameter int ADDR_BITS = 10
) (
	input  wire logic                  clk,
	input  wire logic                  rst_n,

	// load side
	input  wire logic                  i_load_start,
	input  wire logic                  i_entry_strobe,
	input  wire logic [ENTRY_BITS-1:0] i_entry,
	input  wire logic [WORD_BITS-1:0]  i_packed_word,

	// init side
	input  wire logic                  i_init,
	input  wire logic [WORD_BITS-1:0]  i_cleared_word,
	input  wire logic [WORD_BITS-1:0]  i_mem_rdata,

	// PE side
	input  wire logic                  i_pe_request,
	input  wire logic                  i_pe_send,
	input  wire logic [WORD_BITS-1:0]  i_send_data,

	// memory
	output logic                       o_mem_cen_n,
	output logic                       o_mem_wen_n,
	output logic      [ADDR_BITS-1:0]  o_mem_addr,
	output logic      [WORD_BITS-1:0]  o_mem_wdata,

	// status
	output logic      [WORD_BITS-1:0]  o_rd_data,
	output logic                       o_rd_valid,
	output logic      [SIZE_BITS-1:0]  o_t_size,
	output logic                       o_busy
);

	ctrl_state_t state;
	ctrl_state_t state_nxt;

	// read phase, 0 when no read is in flight
	logic [1:0] rd_phase;
	logic [1:0] rd_phase_nxt;

	logic [HEADER_BITS-1:0] header;
	logic [HEADER_BITS-1:0] header_nxt;

	logic [ADDR_BITS-1:0] read_addr;
	logic [ADDR_BITS-1:0] read_addr_nxt;
	logic [ADDR_BITS-1:0] write_addr;
	logic [ADDR_BITS-1:0] write_addr_nxt;
	// address of the last loaded word
	logic [ADDR_BITS-1:0] data_addr;
	logic [ADDR_BITS-1:0] data_addr_nxt;

	logic [WORD_BITS-1:0] rd_data_nxt;
	logic                 rd_valid_nxt;
	logic [SIZE_BITS-1:0] t_size_nxt;
	logic                 busy_nxt;

	logic                 mem_cen_n_nxt;
	logic                 mem_wen_n_nxt;
	logic [ADDR_BITS-1:0] mem_addr_nxt;
	logic [WORD_BITS-1:0] mem_wdata_nxt;

	logic                         entry_valid;
	logic [2:0]                   entry_last;
	logic [WORD_BITS-HEADER_BITS-1:0] send_body;

	assign entry_valid = i_entry[ENTRY_VALID_POS];
	assign entry_last = i_entry[ENTRY_LAST_HI:ENTRY_LAST_LO];
	assign send_body = i_send_data[WORD_BITS-HEADER_BITS-1:0];

	always_comb begin
		state_nxt = state;
		header_nxt = header;
		read_addr_nxt = read_addr;
		write_addr_nxt = write_addr;
		data_addr_nxt = data_addr;
		t_size_nxt = o_t_size;
		busy_nxt = o_busy;

		// a read in flight runs to completion in any state
		rd_phase_nxt = (rd_phase == 2'd0) ? 2'd0 : rd_phase + 2'd1;
		rd_valid_nxt = (rd_phase == 2'd2);
		rd_data_nxt = (rd_phase == 2'd2) ? i_mem_rdata : o_rd_data;

		// memory idle unless a branch below uses it
		mem_cen_n_nxt = 1'b1;
		mem_wen_n_nxt = 1'b1;
		mem_addr_nxt = o_mem_addr;
		mem_wdata_nxt = o_mem_wdata;

		case (state)
			IDLE: begin
				if (i_init) begin
					state_nxt = INIT_READ;
					busy_nxt = 1'b1;
					read_addr_nxt = '0;
					write_addr_nxt = '0;
				end else if (i_load_start) begin
					state_nxt = LOAD;
					busy_nxt = 1'b1;
					read_addr_nxt = '0;
					write_addr_nxt = '0;
					data_addr_nxt = '0;
					t_size_nxt = '0;
				end else if (i_pe_send) begin
					mem_cen_n_nxt = 1'b0;
					mem_wen_n_nxt = 1'b0;
					mem_addr_nxt = write_addr;
					if (write_addr == data_addr) begin
						mem_wdata_nxt = {header, send_body};
						write_addr_nxt = '0;
					end else begin
						mem_wdata_nxt = {FREE_HEADER, send_body};
						write_addr_nxt = write_addr + 1'b1;
					end
				end else if (i_pe_request && rd_phase == 2'd0) begin
					mem_cen_n_nxt = 1'b0;
					mem_addr_nxt = read_addr;
					rd_phase_nxt = 2'd1;
					read_addr_nxt = (read_addr == data_addr) ? '0 : read_addr + 1'b1;
				end
			end

			LOAD: begin
				// invalid descriptors are dropped
				if (i_entry_strobe && entry_valid) begin
					mem_cen_n_nxt = 1'b0;
					mem_wen_n_nxt = 1'b0;
					mem_addr_nxt = data_addr;
					mem_wdata_nxt = i_packed_word;
					if (entry_last != 3'd0) begin
						state_nxt = IDLE;
						busy_nxt = 1'b0;
						header_nxt = i_entry[ENTRY_VALID_POS -: HEADER_BITS];
						t_size_nxt = o_t_size + SIZE_BITS'(entry_last);
					end else if (data_addr == '1) begin
						// store full, close it with the full header
						mem_wdata_nxt = {FULL_HEADER,
							i_packed_word[WORD_BITS-HEADER_BITS-1:0]};
						state_nxt = IDLE;
						busy_nxt = 1'b0;
						header_nxt = FULL_HEADER;
						t_size_nxt = o_t_size + SIZE_BITS'(TUPLES_PER_WORD);
					end else begin
						data_addr_nxt = data_addr + 1'b1;
						t_size_nxt = o_t_size + SIZE_BITS'(TUPLES_PER_WORD);
					end
				end
			end

			INIT_READ: begin
				mem_cen_n_nxt = 1'b0;
				mem_addr_nxt = read_addr;
				state_nxt = INIT_MODIFY;
			end

			INIT_MODIFY: begin
				// memory word lands on this edge
				state_nxt = INIT_WRITE;
			end

			INIT_WRITE: begin
				mem_cen_n_nxt = 1'b0;
				mem_wen_n_nxt = 1'b0;
				mem_addr_nxt = read_addr;
				mem_wdata_nxt = i_cleared_word;
				if (read_addr == data_addr) begin
					state_nxt = IDLE;
					busy_nxt = 1'b0;
					read_addr_nxt = '0;
				end else begin
					state_nxt = INIT_READ;
					read_addr_nxt = read_addr + 1'b1;
				end
			end

			default: begin
				state_nxt = IDLE;
				busy_nxt = 1'b0;
			end
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= IDLE;
			rd_phase <= 2'd0;
			header <= FREE_HEADER;
			read_addr <= '0;
			write_addr <= '0;
			data_addr <= '0;
			o_rd_data <= '0;
			o_rd_valid <= 1'b0;
			o_t_size <= '0;
			o_busy <= 1'b0;
			o_mem_cen_n <= 1'b1;
			o_mem_wen_n <= 1'b1;
			o_mem_addr <= '0;
			o_mem_wdata <= '0;
		end else begin
			state <= state_nxt;
			rd_phase <= rd_phase_nxt;
			header <= header_nxt;
			read_addr <= read_addr_nxt;
			write_addr <= write_addr_nxt;
			data_addr <= data_addr_nxt;
			o_rd_data <= rd_data_nxt;
			o_rd_valid <= rd_valid_nxt;
			o_t_size <= t_size_nxt;
			o_busy <= busy_nxt;
			o_mem_cen_n <= mem_cen_n_nxt;
			o_mem_wen_n <= mem_wen_n_nxt;
			o_mem_addr <= mem_addr_nxt;
			o_mem_wdata <= mem_wdata_nxt;
		end
	end

endmodule

`default_nettype wire

// ==== source/sram_subsys.sv ====
`timescale 1ns/100ps
`default_nettype none

module sram_subsys
	import store_cfg_pkg::*;
	import tentry_pkg::*;
#(
	parameter int ADDR_BITS = 10
) (
	input  wire logic                  clk,
	input  wire logic                  rst_n,
	input  wire logic                  i_load_start,
	input  wire logic                  i_load_req,
	input  wire logic [ENTRY_BITS-1:0] i_load_entry,
	output logic                       o_load_ack,
	input  wire logic                  i_init,
	input  wire logic                  i_pe_request,
	input  wire logic                  i_pe_send,
	input  wire logic [WORD_BITS-1:0]  i_send_data,
	output logic      [WORD_BITS-1:0]  o_rd_data,
	output logic                       o_rd_valid,
	output logic      [SIZE_BITS-1:0]  o_t_size,
	output logic                       o_busy
);

	// host descriptor path
	logic                  entry_strobe;
	logic [ENTRY_BITS-1:0] entry;
	logic [WORD_BITS-1:0]  packed_word;
	logic [WORD_BITS-1:0]  cleared_word;

	// memory bus
	logic                  mem_cen_n;
	logic                  mem_wen_n;
	logic [ADDR_BITS-1:0]  mem_addr;
	logic [WORD_BITS-1:0]  mem_wdata;
	logic [WORD_BITS-1:0]  mem_rdata;

	load_port u_load_port (
		.clk            (clk),
		.rst_n          (rst_n),
		.i_load_req     (i_load_req),
		.i_load_entry   (i_load_entry),
		.o_load_ack     (o_load_ack),
		.o_entry_strobe (entry_strobe),
		.o_entry        (entry)
	);

	// packer serves both the load path and the init pass
	tentry_packer u_tentry_packer (
		.i_entry        (entry),
		.i_word         (mem_rdata),
		.o_packed_word  (packed_word),
		.o_cleared_word (cleared_word)
	);

	sram_controller #(
		.ADDR_BITS (ADDR_BITS)
	) u_sram_controller (
		.clk            (clk),
		.rst_n          (rst_n),
		.i_load_start   (i_load_start),
		.i_entry_strobe (entry_strobe),
		.i_entry        (entry),
		.i_packed_word  (packed_word),
		.i_init         (i_init),
		.i_cleared_word (cleared_word),
		.i_mem_rdata    (mem_rdata),
		.i_pe_request   (i_pe_request),
		.i_pe_send      (i_pe_send),
		.i_send_data    (i_send_data),
		.o_mem_cen_n    (mem_cen_n),
		.o_mem_wen_n    (mem_wen_n),
		.o_mem_addr     (mem_addr),
		.o_mem_wdata    (mem_wdata),
		.o_rd_data      (o_rd_data),
		.o_rd_valid     (o_rd_valid),
		.o_t_size       (o_t_size),
		.o_busy         (o_busy)
	);

	word_sram #(
		.ADDR_BITS (ADDR_BITS)
	) u_word_sram (
		.clk     (clk),
		.i_cen_n (mem_cen_n),
		.i_wen_n (mem_wen_n),
		.i_addr  (mem_addr),
		.i_wdata (mem_wdata),
		.o_rdata (mem_rdata)
	);

endmodule

`default_nettype wire

// ==== source/store_cfg_pkg.sv ====
`default_nettype none

package store_cfg_pkg;

	// one storage word
	localparam int WORD_BITS = 256;

	// header sits in the top bits of a word
	localparam int HEADER_BITS = 4;

	// slot layout below the header, slot 0 at the bottom
	localparam int SLOT_COUNT = 7;
	localparam int SLOT_BITS = 36;

	// value on top of each slot, accumulation field below it
	localparam int VALUE_BITS = 2;
	localparam int ACC_BITS = 34;

	// tuple accounting
	localparam int TUPLES_PER_WORD = 7;
	localparam int SIZE_BITS = 16;

	// header for PE writes away from the last word
	localparam logic [HEADER_BITS-1:0] FREE_HEADER = 4'b1000;

	// header forced when the load runs out of addresses
	localparam logic [HEADER_BITS-1:0] FULL_HEADER = 4'b1111;

endpackage

`default_nettype wire

// ==== source/tentry_packer.sv ====
`timescale 1ns/100ps
`default_nettype none

module tentry_packer
	import store_cfg_pkg::*;
	import tentry_pkg::*;
(
	input  wire logic [ENTRY_BITS-1:0] i_entry,
	input  wire logic [WORD_BITS-1:0]  i_word,
	output logic      [WORD_BITS-1:0]  o_packed_word,
	output logic      [WORD_BITS-1:0]  o_cleared_word
);

	logic [ENTRY_VALUES_BITS-1:0] entry_values;
	logic [HEADER_BITS-1:0]       entry_header;

	// valid bit and last count form the stored header
	assign entry_header = i_entry[ENTRY_VALID_POS -: HEADER_BITS];
	assign entry_values = i_entry[ENTRY_VALUES_BITS-1:0];

	// descriptor into word, accumulation fields start at zero
	always_comb begin
		o_packed_word = '0;
		o_packed_word[WORD_BITS-1 -: HEADER_BITS] = entry_header;
		for (int k = 0; k < SLOT_COUNT; k++) begin
			o_packed_word[k*SLOT_BITS + ACC_BITS +: VALUE_BITS] =
				entry_values[k*VALUE_BITS +: VALUE_BITS];
		end
	end

	// stored word with every accumulation field cleared
	always_comb begin
		o_cleared_word = '0;
		o_cleared_word[WORD_BITS-1 -: HEADER_BITS] = i_word[WORD_BITS-1 -: HEADER_BITS];
		for (int k = 0; k < SLOT_COUNT; k++) begin
			o_cleared_word[k*SLOT_BITS + ACC_BITS +: VALUE_BITS] =
				i_word[k*SLOT_BITS + ACC_BITS +: VALUE_BITS];
		end
	end

endmodule

`default_nettype wire

// ==== source/tentry_pkg.sv ====
`default_nettype none

package tentry_pkg;

	// host descriptor width
	localparam int ENTRY_BITS = 18;

	// descriptor is valid when this bit is set
	localparam int ENTRY_VALID_POS = 17;

	// last-count field, non-zero on the final descriptor
	localparam int ENTRY_LAST_HI = 16;
	localparam int ENTRY_LAST_LO = 14;

	// value pairs, two bits per slot, slot 0 in the lsbs
	localparam int ENTRY_VALUES_BITS = 14;

	// controller states
	typedef enum logic [2:0] {
		// waiting for start pulses and PE traffic
		IDLE,
		// taking strobed descriptors from the load port
		LOAD,
		// init pass, issue the read of the current word
		INIT_READ,
		// init pass, memory read in progress
		INIT_MODIFY,
		// init pass, write back the cleared word
		INIT_WRITE
	} ctrl_state_t;

endpackage

`default_nettype wire

// ==== source/word_sram.sv ====
`timescale 1ns/100ps
`default_nettype none

module word_sram
	import store_cfg_pkg::*;
#(
	parameter int ADDR_BITS = 10
) (
	input  wire logic                 clk,
	input  wire logic                 i_cen_n,
	input  wire logic                 i_wen_n,
	input  wire logic [ADDR_BITS-1:0] i_addr,
	input  wire logic [WORD_BITS-1:0] i_wdata,
	output logic      [WORD_BITS-1:0] o_rdata
);

	localparam int DEPTH = 1 << ADDR_BITS;

	logic [WORD_BITS-1:0] mem [DEPTH];

	// read data only changes on an enabled read cycle
	always_ff @(posedge clk) begin
		if (!i_cen_n) begin
			if (!i_wen_n) begin
				mem[i_addr] <= i_wdata;
			end else begin
				o_rdata <= mem[i_addr];
			end
		end
	end

endmodule

`default_nettype wire

// ==== sram_subsys.f ====
source/store_cfg_pkg.sv
source/tentry_pkg.sv
source/word_sram.sv
source/tentry_packer.sv
source/load_port.sv
source/sram_controller.sv
source/sram_subsys.sv
bench/tb_sram_subsys.sv
